// File: compile.f
+incdir+verilog
verilog/plot_pkg.sv
verilog/column_plotter.sv
verilog/plot_arbiter.sv
verilog/frame_buffer.sv
verilog/pixel_plotter.sv
verification/tb_clock_gen.sv
verification/plot_checker.sv
verification/plot_asserts.sv
verification/tb_pixel_plotter.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pixel plotter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_pixel_plotter -Mdir obj_dir -f compile.f \
	> "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_pixel_plotter > "$LOG" 2>&1 \
	|| { cat "$LOG"; echo "Simulation exited with an error status"; exit 1; }

cat "$LOG"
grep -q "Simulation FAILED" "$LOG" && { echo "Failure reported in $LOG"; exit 1; }
grep -q "Simulation PASSED" "$LOG" || { echo "No pass line found in $LOG"; exit 1; }
exit 0

// File: verification/plot_asserts.sv
/* Arbiter protocol assertions */

`timescale 1ns/100ps
`default_nettype none

`include "plot_params.svh"

module plot_asserts (
	input wire logic                     CLOCK_50,
	input wire logic                     reset,
	input wire logic [`PLOT_COLUMNS-1:0] plot_request,
	input wire logic [`PLOT_COLUMNS-1:0] plot_complete,
	input wire logic                     fb_write
);

	//////////////////////////////////////////////////
	// Write port usage
	//////////////////////////////////////////////////

	// One grant per cycle at most
	one_completion: assert property (
		@(posedge CLOCK_50) disable iff (reset) $onehot0(plot_complete)
	) else $error("More than one completion pulse in the same cycle");

	// Buffer write lines up with the completion
	write_with_completion: assert property (
		@(posedge CLOCK_50) disable iff (reset) fb_write == (|plot_complete)
	) else $error("Frame buffer write without a matching completion");

	//////////////////////////////////////////////////
	// Completion pulses
	//////////////////////////////////////////////////

	// No column acknowledged twice in a row
	single_cycle_pulse: assert property (
		@(posedge CLOCK_50) disable iff (reset)
			(plot_complete & $past(plot_complete)) == '0
	) else $error("Completion pulse longer than one cycle");

	// Only a requesting column gets a pulse
	complete_on_request: assert property (
		@(posedge CLOCK_50) disable iff (reset)
			(plot_complete & ~plot_request) == '0
	) else $error("Completion pulse for a column with no request");

endmodule

bind plot_arbiter plot_asserts i_plot_asserts (
	.CLOCK_50      (CLOCK_50),
	.reset         (reset),
	.plot_request  (plot_request),
	.plot_complete (plot_complete),
	.fb_write      (fb_write)
);

`default_nettype wire

// File: verification/plot_checker.sv
/* Pixel plotter checker */

`timescale 1ns/100ps
`default_nettype none

`include "plot_params.svh"

module plot_checker
	import plot_pkg::*;
(
	input  wire logic                     CLOCK_50,
	input  wire logic                     reset,
	input  wire logic [`PLOT_COLUMNS-1:0] col_select,
	input  wire row_t                     row_select,
	input  wire pixel_t                   pixel_color,
	input  wire logic [`PLOT_COLUMNS-1:0] col_done,
	input  wire fb_addr_t                 rd_addr,
	input  wire logic                     rd_valid,
	input  wire pixel_t                   rd_data,
	input  wire logic [2:0]               test_id,
	output int                            error_count,
	output int                            check_count
);

	localparam int DEPTH = `PLOT_ROWS * `SCREEN_WIDTH;

	// Frame buffer model and its written map
	pixel_t model [DEPTH];
	logic   written [DEPTH];

	// Per-column view of the plotter handshake
	logic [`PLOT_COLUMNS-1:0] busy;
	logic [`PLOT_COLUMNS-1:0] released;
	logic [`PLOT_COLUMNS-1:0] done_q;
	row_t                     cap_row [`PLOT_COLUMNS];
	pixel_t                   cap_color [`PLOT_COLUMNS];
	int                       hold_cnt [`PLOT_COLUMNS];

	// Read pipeline, data shows one cycle after the address
	logic       reset_q;
	logic       rd_compare;
	pixel_t     rd_expect;
	int         rd_index;
	logic [2:0] rd_test;
	int         addr;

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1:    return "single_plot";
			3'd2:    return "contention";
			3'd3:    return "done_release";
			3'd4:    return "overwrite";
			default: return "soak";
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Sampling and compare
	//////////////////////////////////////////////////

	always @(posedge CLOCK_50) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				written[i] = 1'b0;
			end
			busy       = '0;
			released   = '0;
			rd_compare = 1'b0;
			for (int c = 0; c < `PLOT_COLUMNS; c++) begin
				hold_cnt[c] = 0;
			end
		end else begin
			// First cycle out of reset
			if (reset_q) begin
				check_count++;
				if (col_done !== '0) begin
					error_count++;
					$display("CHECK FAILED reset_state: col_done expected %02h actual %02h",
						`PLOT_COLUMNS'(0), col_done);
				end
			end
			// Read data for the address sampled last cycle
			if (rd_compare) begin
				check_count++;
				if (rd_data !== rd_expect) begin
					error_count++;
					$display("CHECK FAILED %s: address %0d expected %02h actual %02h",
						test_name(rd_test), rd_index, rd_expect, rd_data);
				end
			end
			for (int c = 0; c < `PLOT_COLUMNS; c++) begin
				// Done rising marks the pixel as written
				if (col_done[c] && !done_q[c]) begin
					if (!busy[c]) begin
						error_count++;
						$display("ERROR: column %0d raised done without a select", c);
					end
					addr = c + int'(cap_row[c]) * `SCREEN_WIDTH;
					if (addr < DEPTH) begin
						model[addr]   = cap_color[c];
						written[addr] = 1'b1;
					end
				end
				// Done falling one cycle after the release was seen
				if (!col_done[c] && done_q[c]) begin
					check_count++;
					if (!released[c]) begin
						error_count++;
						$display("ERROR: column %0d dropped done while select was held", c);
					end else if (hold_cnt[c] < 2) begin
						error_count++;
						$display("ERROR: column %0d dropped done too early after select dropped",
							c);
					end
					busy[c]     = 1'b0;
					released[c] = 1'b0;
					hold_cnt[c] = 0;
				end
				// Select seen low while done is up
				if (col_done[c] && !col_select[c]) begin
					released[c] = 1'b1;
					hold_cnt[c]++;
					if (hold_cnt[c] == 3) begin
						error_count++;
						$display("ERROR: column %0d kept done high after select dropped", c);
					end
				end
				// Acceptance from idle latches row and colour
				if (!busy[c] && col_select[c]) begin
					busy[c]      = 1'b1;
					cap_row[c]   = row_select;
					cap_color[c] = pixel_color;
				end
			end
			// Expected value taken after this cycle's model update
			rd_compare = 1'b0;
			rd_index   = int'(rd_addr);
			if (rd_valid && rd_index < DEPTH) begin
				if (written[rd_index]) begin
					rd_compare = 1'b1;
					rd_expect  = model[rd_index];
					rd_test    = test_id;
				end
			end
		end
		reset_q = reset;
		done_q  = col_done;
	end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
/* Testbench clock and reset */

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic CLOCK_50,
	output logic reset
);

	// Free running 40 ns clock
	initial begin
		CLOCK_50 = 1'b0;
		forever #(HALF_PERIOD) CLOCK_50 = ~CLOCK_50;
	end

	// Reset held over the first cycles
	initial begin
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge CLOCK_50);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: verification/tb_pixel_plotter.sv
/* Pixel plotter testbench */

`timescale 1ns/100ps
`default_nettype none

`include "plot_params.svh"

module tb_pixel_plotter
	import plot_pkg::*;
();

	typedef logic [`PLOT_COLUMNS-1:0] col_mask_t;

	localparam int CLOCK_NS     = 40;
	localparam int RESET_CYCLES = 10;
	localparam int SOAK_ITERS   = 40;
	localparam int DONE_TIMEOUT = 40;
	// Plot and read operations over all tests
	localparam int TEST_OPS     = 2 + 16 + 1 + 3 + 2 * SOAK_ITERS;
	localparam int WATCHDOG_NS  = TEST_OPS * 40 * CLOCK_NS + RESET_CYCLES * CLOCK_NS;

	logic           CLOCK_50;
	logic           reset;
	col_mask_t      col_select;
	row_t           row_select;
	pixel_t         pixel_color;
	fb_addr_t       rd_addr;
	wire col_mask_t col_done;
	wire pixel_t    rd_data;

	logic       rd_valid;
	logic [2:0] test_id;
	int         seed;
	int         tb_errors;
	int         checker_errors;
	int         check_count;

	tb_clock_gen #(
		.HALF_PERIOD  (CLOCK_NS / 2),
		.RESET_CYCLES (RESET_CYCLES)
	) i_tb_clock_gen (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset)
	);

	pixel_plotter i_pixel_plotter (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.col_select  (col_select),
		.row_select  (row_select),
		.pixel_color (pixel_color),
		.rd_addr     (rd_addr),
		.col_done    (col_done),
		.rd_data     (rd_data)
	);

	plot_checker i_plot_checker (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.col_select  (col_select),
		.row_select  (row_select),
		.pixel_color (pixel_color),
		.col_done    (col_done),
		.rd_addr     (rd_addr),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data),
		.test_id     (test_id),
		.error_count (checker_errors),
		.check_count (check_count)
	);

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	function automatic int rand_below(input int limit);
		int value;
		value = $random(seed);
		return (value & 32'h7fff_ffff) % limit;
	endfunction

	// Polls done at each edge, bounded by the timeout
	task automatic wait_done(input int col, input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(posedge CLOCK_50);
			cycles++;
		end while (col_done[col] != level && cycles < DONE_TIMEOUT);
		if (col_done[col] != level) begin
			tb_errors++;
			if (level) begin
				$display("ERROR: column %0d done never rose within %0d cycles", col, DONE_TIMEOUT);
			end else begin
				$display("ERROR: column %0d done never cleared within %0d cycles", col,
					DONE_TIMEOUT);
			end
		end
	endtask

	task automatic wait_columns(input col_mask_t mask, input logic level);
		for (int c = 0; c < `PLOT_COLUMNS; c++) begin
			if (mask[c]) begin
				wait_done(c, level);
			end
		end
	endtask

	task automatic start_plot(input col_mask_t mask, input row_t row, input pixel_t color);
		@(posedge CLOCK_50);
		col_select  <= col_select | mask;
		row_select  <= row;
		pixel_color <= color;
	endtask

	task automatic release_plot(input col_mask_t mask);
		@(posedge CLOCK_50);
		col_select <= col_select & ~mask;
		wait_columns(mask, 1'b0);
	endtask

	task automatic read_pixel(input int addr);
		@(posedge CLOCK_50);
		rd_addr  <= fb_addr_t'(addr);
		rd_valid <= 1'b1;
		@(posedge CLOCK_50);
		rd_valid <= 1'b0;
	endtask

	// Full plot of one column then read back
	task automatic plot_column(input int col, input row_t row, input pixel_t color,
		input int hold);
		col_mask_t mask;
		mask = col_mask_t'(1) << col;
		start_plot(mask, row, color);
		wait_done(col, 1'b1);
		repeat (hold) @(posedge CLOCK_50);
		release_plot(mask);
		read_pixel(col + int'(row) * `SCREEN_WIDTH);
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic run_contention();
		col_mask_t mask;
		col_mask_t batch;
		row_t      row_a;
		row_t      row_b;
		mask  = col_mask_t'(rand_below(255) + 1);
		batch = col_mask_t'(rand_below(256)) & mask;
		row_a = row_t'(rand_below(`PLOT_ROWS));
		row_b = row_t'(rand_below(`PLOT_ROWS));
		// Two groups back to back with their own row and colour
		start_plot(mask & ~batch, row_a, pixel_t'(rand_below(256)));
		start_plot(mask & batch, row_b, pixel_t'(rand_below(256)));
		wait_columns(mask, 1'b1);
		release_plot(mask);
		for (int c = 0; c < `PLOT_COLUMNS; c++) begin
			if (mask[c]) begin
				read_pixel(c + int'(batch[c] ? row_b : row_a) * `SCREEN_WIDTH);
			end
		end
	endtask

	task automatic run_soak();
		col_mask_t mask;
		row_t      row;
		for (int it = 0; it < SOAK_ITERS; it++) begin
			mask = col_mask_t'(rand_below(255) + 1);
			row  = row_t'(rand_below(`PLOT_ROWS));
			start_plot(mask, row, pixel_t'(rand_below(256)));
			wait_columns(mask, 1'b1);
			repeat (rand_below(4)) @(posedge CLOCK_50);
			release_plot(mask);
			for (int c = 0; c < `PLOT_COLUMNS; c++) begin
				if (mask[c]) begin
					read_pixel(c + int'(row) * `SCREEN_WIDTH);
				end
			end
			read_pixel(rand_below(`PLOT_ROWS * `SCREEN_WIDTH));
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		int     col;
		row_t   row;
		pixel_t first;
		seed      = 84262;
		tb_errors = 0;
		col_select  <= '0;
		row_select  <= '0;
		pixel_color <= '0;
		rd_addr     <= '0;
		rd_valid    <= 1'b0;
		test_id     <= 3'd5;
		@(negedge reset);
		@(posedge CLOCK_50);
		test_id <= 3'd1;
		plot_column(rand_below(`PLOT_COLUMNS), row_t'(rand_below(`PLOT_ROWS)),
			pixel_t'(rand_below(256)), 0);
		test_id <= 3'd2;
		run_contention();
		test_id <= 3'd3;
		plot_column(rand_below(`PLOT_COLUMNS), row_t'(rand_below(`PLOT_ROWS)),
			pixel_t'(rand_below(256)), rand_below(10) + 1);
		// Same location twice, second colour differs
		test_id <= 3'd4;
		col   = rand_below(`PLOT_COLUMNS);
		row   = row_t'(rand_below(`PLOT_ROWS));
		first = pixel_t'(rand_below(256));
		plot_column(col, row, first, 0);
		plot_column(col, row, first ^ pixel_t'(rand_below(255) + 1), 0);
		test_id <= 3'd5;
		run_soak();
		repeat (4) @(posedge CLOCK_50);
		$display("Checks %0d, checker errors %0d, testbench errors %0d",
			check_count, checker_errors, tb_errors);
		if (checker_errors == 0 && tb_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Watchdog over the whole run
	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/column_plotter.sv
/* Single column plotter */

`timescale 1ns/100ps
`default_nettype none

`include "plot_params.svh"

module column_plotter
	import plot_pkg::*;
#(
	parameter int COLUMN_INDEX = 0
) (
	input  wire logic   CLOCK_50,
	input  wire logic   reset,
	input  wire logic   col_select,
	input  wire row_t   row_select,
	input  wire pixel_t pixel_color,
	input  wire logic   plot_complete,
	output logic        plot_request,
	output plot_req_t   plot_req,
	output logic        col_done
);

	// X coordinate of this column
	localparam fb_addr_t COLUMN_X = fb_addr_t'(COLUMN_INDEX);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_GRANT,
		ST_DONE,
		ST_RELEASE
	} state_t;

	state_t   state;
	logic     accept;
	fb_addr_t row_offset;

	//////////////////////////////////////////////////
	// Address rule
	//////////////////////////////////////////////////

	// Row stride, base address is zero
	assign row_offset = fb_addr_t'(row_select * `SCREEN_WIDTH);
	// New select only taken from idle
	assign accept = (state == ST_IDLE) && col_select;

	// Address and colour captured at the accepting edge
	always_ff @(posedge CLOCK_50) begin
		if (accept) begin
			plot_req.addr  <= COLUMN_X + row_offset;
			plot_req.color <= pixel_color;
		end
	end

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state        <= ST_IDLE;
			plot_request <= 1'b0;
			col_done     <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (col_select) begin
						plot_request <= 1'b1;
						state        <= ST_WAIT_GRANT;
					end
				end
				// Hold request until the arbiter pulses back
				ST_WAIT_GRANT: begin
					if (plot_complete) begin
						plot_request <= 1'b0;
						col_done     <= 1'b1;
						state        <= ST_DONE;
					end
				end
				// Done held while the host keeps select high
				ST_DONE: begin
					if (!col_select) begin
						state <= ST_RELEASE;
					end
				end
				ST_RELEASE: begin
					col_done <= 1'b0;
					state    <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/frame_buffer.sv
/* On-chip frame buffer */

`timescale 1ns/100ps
`default_nettype none

`include "plot_params.svh"

module frame_buffer
	import plot_pkg::*;
(
	input  wire logic      CLOCK_50,
	input  wire logic      fb_write,
	input  wire plot_req_t fb_req,
	input  wire fb_addr_t  rd_addr,
	output pixel_t         rd_data
);

	// One entry per pixel over all rows
	localparam int DEPTH = `PLOT_ROWS * `SCREEN_WIDTH;

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	pixel_t mem [DEPTH];

	// Block RAM style, one write and one registered read
	always_ff @(posedge CLOCK_50) begin
		if (fb_write) begin
			mem[fb_req.addr] <= fb_req.color;
		end
		// Old contents on a same-address write
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: verilog/pixel_plotter.sv
/* Pixel plotter top */

`timescale 1ns/100ps
`default_nettype none

`include "plot_params.svh"

module pixel_plotter
	import plot_pkg::*;
(
	input  wire logic                     CLOCK_50,
	input  wire logic                     reset,
	input  wire logic [`PLOT_COLUMNS-1:0] col_select,
	input  wire row_t                     row_select,
	input  wire pixel_t                   pixel_color,
	input  wire fb_addr_t                 rd_addr,
	output wire logic [`PLOT_COLUMNS-1:0] col_done,
	output wire pixel_t                   rd_data
);

	// Per-column request levels and completion pulses
	wire logic [`PLOT_COLUMNS-1:0] col_request;
	wire logic [`PLOT_COLUMNS-1:0] col_complete;
	// Address and colour from each plotter
	wire plot_req_t col_req [`PLOT_COLUMNS];

	// Single write port into the buffer
	wire logic      fb_write;
	wire plot_req_t fb_req;

	//////////////////////////////////////////////////
	// Column plotters
	//////////////////////////////////////////////////

	genvar i;
	generate
		for (i = 0; i < `PLOT_COLUMNS; i++) begin : gen_column
			column_plotter #(
				.COLUMN_INDEX (i)
			) i_column_plotter (
				.CLOCK_50      (CLOCK_50),
				.reset         (reset),
				.col_select    (col_select[i]),
				.row_select    (row_select),
				.pixel_color   (pixel_color),
				.plot_complete (col_complete[i]),
				.plot_request  (col_request[i]),
				.plot_req      (col_req[i]),
				.col_done      (col_done[i])
			);
		end
	endgenerate

	//////////////////////////////////////////////////
	// Write port arbitration and storage
	//////////////////////////////////////////////////

	plot_arbiter i_plot_arbiter (
		.CLOCK_50      (CLOCK_50),
		.reset         (reset),
		.plot_request  (col_request),
		.plot_req      (col_req),
		.plot_complete (col_complete),
		.fb_write      (fb_write),
		.fb_req        (fb_req)
	);

	frame_buffer i_frame_buffer (
		.CLOCK_50 (CLOCK_50),
		.fb_write (fb_write),
		.fb_req   (fb_req),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

endmodule

`default_nettype wire

// File: verilog/plot_arbiter.sv
/* Frame buffer write arbiter */

`timescale 1ns/100ps
`default_nettype none

`include "plot_params.svh"

module plot_arbiter
	import plot_pkg::*;
(
	input  wire logic                     CLOCK_50,
	input  wire logic                     reset,
	input  wire logic [`PLOT_COLUMNS-1:0] plot_request,
	input  wire plot_req_t                plot_req [`PLOT_COLUMNS],
	output logic [`PLOT_COLUMNS-1:0]      plot_complete,
	output logic                          fb_write,
	output plot_req_t                     fb_req
);

	localparam int IDX_WIDTH = $clog2(`PLOT_COLUMNS);

	logic [`PLOT_COLUMNS-1:0] pending;
	logic [`PLOT_COLUMNS-1:0] grant;
	logic [IDX_WIDTH-1:0]     grant_idx;
	logic                     grant_valid;

	//////////////////////////////////////////////////
	// Priority select
	//////////////////////////////////////////////////

	// Column being acknowledged this cycle still shows its request
	assign pending = plot_request & ~plot_complete;

	// Lowest index wins, loop runs high to low
	always_comb begin
		grant       = '0;
		grant_idx   = '0;
		grant_valid = 1'b0;
		for (int i = `PLOT_COLUMNS - 1; i >= 0; i--) begin
			if (pending[i]) begin
				grant       = '0;
				grant[i]    = 1'b1;
				grant_idx   = IDX_WIDTH'(i);
				grant_valid = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Registered write port
	//////////////////////////////////////////////////

	// Completion pulse lines up with the buffer write
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			plot_complete <= '0;
			fb_write      <= 1'b0;
		end else begin
			plot_complete <= grant;
			fb_write      <= grant_valid;
		end
	end

	// Payload of the granted column
	always_ff @(posedge CLOCK_50) begin
		if (grant_valid) begin
			fb_req <= plot_req[grant_idx];
		end
	end

endmodule

`default_nettype wire

// File: verilog/plot_params.svh
/* Pixel plotter sizes */

`ifndef PLOT_PARAMS_SVH
`define PLOT_PARAMS_SVH

//////////////////////////////////////////////////
// Screen geometry
//////////////////////////////////////////////////

// Number of column plotters
`define PLOT_COLUMNS 8
// Rows held in the frame buffer
`define PLOT_ROWS 8
// Pixels per row, used for the row stride
`define SCREEN_WIDTH 640

//////////////////////////////////////////////////
// Field widths
//////////////////////////////////////////////////

// Row number as driven by the host
`define ROW_WIDTH 10
// Covers 640 x 8 locations
`define FB_ADDR_WIDTH 13
// One colour byte
`define PIXEL_WIDTH 8

`endif

// File: verilog/plot_pkg.sv
/* Pixel plotter types */

`default_nettype none

`include "plot_params.svh"

package plot_pkg;

	//////////////////////////////////////////////////
	// Scalar fields
	//////////////////////////////////////////////////

	// Colour value
	typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

	// Linear frame buffer address
	typedef logic [`FB_ADDR_WIDTH-1:0] fb_addr_t;

	// Row number from the host
	typedef logic [`ROW_WIDTH-1:0] row_t;

	//////////////////////////////////////////////////
	// Plot request
	//////////////////////////////////////////////////

	// Plotter to arbiter to buffer, 21 bits
	typedef struct packed {
		fb_addr_t addr;
		pixel_t   color;
	} plot_req_t;

endpackage

`default_nettype wire
